// File: mpls_ingress_pkg.sv
/* Shared widths, port map, buffer sizing and enums for the MPLS ingress stage.
   Imported by the ingress modules and the testbench. */
package mpls_ingress_pkg;

  ////////////////////////////////////////////////////////////
  // Converged bus

  localparam int CONV_BYTES = 8;
  localparam int CONV_WIDTH = CONV_BYTES * 8;

  // Byte counter width, holds 0 up to CONV_BYTES
  localparam int CONV_CNT_WIDTH = $clog2(CONV_BYTES + 1);

  ////////////////////////////////////////////////////////////
  // Physical ports

  localparam int NUM_ING_PORTS = 4;

  // Carried on tuser of the converged bus
  localparam int PORT_IDX_WIDTH = $clog2(NUM_ING_PORTS);

  ////////////////////////////////////////////////////////////
  // Packet buffers

  // 32 words of 8 bytes, so 256 bytes per port
  localparam int BUF_DEPTH_WORDS = 32;
  localparam int BUF_ADDR_WIDTH = $clog2(BUF_DEPTH_WORDS);

  // Extra MSB is the wrap bit for full/empty detection
  localparam int BUF_PTR_WIDTH = BUF_ADDR_WIDTH + 1;

  ////////////////////////////////////////////////////////////
  // Enums

  // Port index, also the tuser value on the converged bus
  typedef enum logic [PORT_IDX_WIDTH-1:0] {
    ING_8B_PORT  = 2'd0,
    ING_16B_PORT = 2'd1,
    ING_32B_PORT = 2'd2,
    ING_64B_PORT = 2'd3
  } ing_port_e;

  // Scheduler FSM
  typedef enum logic {
    SCHED_IDLE,
    SCHED_PASS
  } sched_state_e;

endpackage

// File: ing_width_upsizer.sv
/* Packs the beats of one narrow ingress port into 8-byte words with byte keep.
   One instance per physical port, IN_BYTES set to the port width. */
`timescale 1ns/10ps

module ing_width_upsizer #(
  parameter int IN_BYTES = 1
) (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     in_tvalid,
  input  logic [IN_BYTES*8-1:0]                    in_tdata,
  input  logic [IN_BYTES-1:0]                      in_tkeep,
  input  logic                                     in_tlast,
  output logic                                     wide_valid,
  output logic [mpls_ingress_pkg::CONV_WIDTH-1:0]  wide_data,
  output logic [mpls_ingress_pkg::CONV_BYTES-1:0]  wide_keep,
  output logic                                     wide_last
);
  import mpls_ingress_pkg::*;

  logic [CONV_WIDTH-1:0]     acc_data;
  logic [CONV_CNT_WIDTH-1:0] fill_cnt;
  logic [CONV_CNT_WIDTH-1:0] beat_bytes;
  logic [CONV_CNT_WIDTH-1:0] next_fill;
  logic [CONV_WIDTH-1:0]     merged_data;
  logic [CONV_WIDTH-1:0]     masked_data;
  logic [CONV_BYTES-1:0]     merged_keep;
  logic                      word_done;

  // Bytes carried by this beat; keep only counts on a last beat
  always_comb begin
    beat_bytes = CONV_CNT_WIDTH'(IN_BYTES);
    if (in_tlast) begin
      beat_bytes = '0;
      for (int i = 0; i < IN_BYTES; i++) begin
        beat_bytes = beat_bytes + CONV_CNT_WIDTH'(in_tkeep[i]);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Lane merge

  always_comb begin
    merged_data = acc_data;
    // Fill count is always a multiple of IN_BYTES here
    merged_data[fill_cnt*8 +: IN_BYTES*8] = in_tdata;

    next_fill = fill_cnt + beat_bytes;
    word_done = in_tvalid && (in_tlast || (next_fill == CONV_CNT_WIDTH'(CONV_BYTES)));

    for (int j = 0; j < CONV_BYTES; j++) begin
      merged_keep[j] = (j < next_fill);
      // Unused lanes go out as zero
      masked_data[j*8 +: 8] = merged_keep[j] ? merged_data[j*8 +: 8] : 8'h00;
    end
  end

  ////////////////////////////////////////////////////////////
  // Registers

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fill_cnt   <= '0;
      wide_valid <= 1'b0;
    end else begin
      wide_valid <= word_done;
      if (word_done) begin
        fill_cnt <= '0;
      end else if (in_tvalid) begin
        fill_cnt <= next_fill;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_tvalid) begin
      acc_data <= merged_data;
    end
    if (word_done) begin
      wide_data <= masked_data;
      wide_keep <= merged_keep;
      wide_last <= in_tlast;
    end
  end

endmodule

// File: ing_pkt_buffer.sv
/* Per-port packet FIFO between an upsizer and the scheduler.
   Packets commit on their last word; a packet that does not fit is dropped. */
`timescale 1ns/10ps

module ing_pkt_buffer (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     wide_valid,
  input  logic [mpls_ingress_pkg::CONV_WIDTH-1:0]  wide_data,
  input  logic [mpls_ingress_pkg::CONV_BYTES-1:0]  wide_keep,
  input  logic                                     wide_last,
  input  logic                                     pkt_ready,
  output logic                                     pkt_valid,
  output logic [mpls_ingress_pkg::CONV_WIDTH-1:0]  pkt_data,
  output logic [mpls_ingress_pkg::CONV_BYTES-1:0]  pkt_keep,
  output logic                                     pkt_last,
  output logic                                     pkt_avail,
  output logic                                     overflow
);
  import mpls_ingress_pkg::*;

  logic [CONV_WIDTH-1:0]    data_mem [BUF_DEPTH_WORDS];
  logic [CONV_BYTES-1:0]    keep_mem [BUF_DEPTH_WORDS];
  logic                     last_mem [BUF_DEPTH_WORDS];

  // Write, committed and read pointers, all with a wrap bit
  logic [BUF_PTR_WIDTH-1:0] wr_ptr;
  logic [BUF_PTR_WIDTH-1:0] commit_ptr;
  logic [BUF_PTR_WIDTH-1:0] rd_ptr;
  logic [BUF_PTR_WIDTH-1:0] pkt_cnt;

  logic drop_mode;
  logic buf_full;
  logic wr_en;
  logic start_drop;
  logic commit_en;
  logic rd_en;
  logic release_en;

  ////////////////////////////////////////////////////////////
  // Write side

  // Read pointer bounds the space, so committed data is never overwritten
  assign buf_full   = (wr_ptr - rd_ptr) == BUF_PTR_WIDTH'(BUF_DEPTH_WORDS);
  assign wr_en      = wide_valid && !drop_mode && !buf_full;
  assign start_drop = wide_valid && !drop_mode && buf_full;
  assign commit_en  = wr_en && wide_last;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      data_mem[wr_ptr[BUF_ADDR_WIDTH-1:0]] <= wide_data;
      keep_mem[wr_ptr[BUF_ADDR_WIDTH-1:0]] <= wide_keep;
      last_mem[wr_ptr[BUF_ADDR_WIDTH-1:0]] <= wide_last;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read side

  // Head word is visible as soon as it is committed
  assign pkt_valid  = (rd_ptr != commit_ptr);
  assign pkt_data   = data_mem[rd_ptr[BUF_ADDR_WIDTH-1:0]];
  assign pkt_keep   = keep_mem[rd_ptr[BUF_ADDR_WIDTH-1:0]];
  assign pkt_last   = last_mem[rd_ptr[BUF_ADDR_WIDTH-1:0]];
  assign pkt_avail  = (pkt_cnt != '0);
  assign rd_en      = pkt_valid && pkt_ready;
  assign release_en = rd_en && pkt_last;

  ////////////////////////////////////////////////////////////
  // Pointers and drop control

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      commit_ptr <= '0;
      rd_ptr     <= '0;
      pkt_cnt    <= '0;
      drop_mode  <= 1'b0;
      overflow   <= 1'b0;
    end else begin
      // Single pulse at the first discarded word
      overflow <= start_drop;

      if (start_drop) begin
        // Rewind over the partial packet, skip the rest up to tlast
        wr_ptr    <= commit_ptr;
        drop_mode <= !wide_last;
      end else if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
        if (wide_last) begin
          commit_ptr <= wr_ptr + 1'b1;
        end
      end else if (wide_valid && drop_mode && wide_last) begin
        drop_mode <= 1'b0;
      end

      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      case ({commit_en, release_en})
        2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
        2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
        default: pkt_cnt <= pkt_cnt;
      endcase
    end
  end

endmodule

// File: ing_rr_scheduler.sv
/* Round-robin packet scheduler that merges the port buffers onto the converged bus.
   A grant holds for a whole packet and the port index goes out on tuser. */
`timescale 1ns/10ps

module ing_rr_scheduler (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic [mpls_ingress_pkg::NUM_ING_PORTS-1:0]   pkt_avail,
  input  logic [mpls_ingress_pkg::NUM_ING_PORTS-1:0]   pkt_valid,
  input  logic [mpls_ingress_pkg::CONV_WIDTH-1:0]      pkt_data [mpls_ingress_pkg::NUM_ING_PORTS],
  input  logic [mpls_ingress_pkg::CONV_BYTES-1:0]      pkt_keep [mpls_ingress_pkg::NUM_ING_PORTS],
  input  logic [mpls_ingress_pkg::NUM_ING_PORTS-1:0]   pkt_last,
  input  logic                                         out_tready,
  output logic [mpls_ingress_pkg::NUM_ING_PORTS-1:0]   pkt_ready,
  output logic                                         out_tvalid,
  output logic [mpls_ingress_pkg::CONV_WIDTH-1:0]      out_tdata,
  output logic [mpls_ingress_pkg::CONV_BYTES-1:0]      out_tkeep,
  output logic                                         out_tlast,
  output logic [mpls_ingress_pkg::PORT_IDX_WIDTH-1:0]  out_tuser
);
  import mpls_ingress_pkg::*;

  sched_state_e              state;
  // Current grant, also the last port granted while idle
  ing_port_e                 grant;
  ing_port_e                 next_grant;
  logic                      found;
  logic [PORT_IDX_WIDTH-1:0] cand;

  ////////////////////////////////////////////////////////////
  // Rotating search

  // Walk from farthest to nearest so the port right after the
  // last grant wins; the last granted port itself comes last
  always_comb begin
    found      = 1'b0;
    next_grant = grant;
    cand       = '0;
    for (int off = NUM_ING_PORTS; off >= 1; off--) begin
      cand = grant + PORT_IDX_WIDTH'(off);
      if (pkt_avail[cand]) begin
        found      = 1'b1;
        next_grant = ing_port_e'(cand);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // FSM

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= SCHED_IDLE;
      // Port 0 is searched first after reset
      grant <= ING_64B_PORT;
    end else begin
      case (state)
        SCHED_IDLE: begin
          if (found) begin
            grant <= next_grant;
            state <= SCHED_PASS;
          end
        end
        SCHED_PASS: begin
          // Release only after the last beat has transferred
          if (out_tvalid && out_tready && out_tlast) begin
            state <= SCHED_IDLE;
          end
        end
        default: state <= SCHED_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Output mux

  // Buffer head holds while not read, so the bus stays stable under back-pressure
  always_comb begin
    out_tvalid = (state == SCHED_PASS) && pkt_valid[grant];
    out_tdata  = pkt_data[grant];
    out_tkeep  = pkt_keep[grant];
    out_tlast  = pkt_last[grant];
    out_tuser  = grant;

    pkt_ready = '0;
    if (state == SCHED_PASS) begin
      pkt_ready[grant] = out_tready;
    end
  end

endmodule

// File: mpls_ingress.sv
/* Ingress stage top: four port upsizers and packet buffers feeding the scheduler.
   Drives the converged 8-byte bus with the source port on tuser. */
`timescale 1ns/10ps

module mpls_ingress (
  input  logic                                         clk,
  input  logic                                         rst_n,

  input  logic                                         port8b_tvalid,
  input  logic [7:0]                                   port8b_tdata,
  input  logic                                         port8b_tlast,

  input  logic                                         port16b_tvalid,
  input  logic [15:0]                                  port16b_tdata,
  input  logic [1:0]                                   port16b_tkeep,
  input  logic                                         port16b_tlast,

  input  logic                                         port32b_tvalid,
  input  logic [31:0]                                  port32b_tdata,
  input  logic [3:0]                                   port32b_tkeep,
  input  logic                                         port32b_tlast,

  input  logic                                         port64b_tvalid,
  input  logic [63:0]                                  port64b_tdata,
  input  logic [7:0]                                   port64b_tkeep,
  input  logic                                         port64b_tlast,

  output logic                                         out_tvalid,
  output logic [mpls_ingress_pkg::CONV_WIDTH-1:0]      out_tdata,
  output logic [mpls_ingress_pkg::CONV_BYTES-1:0]      out_tkeep,
  output logic                                         out_tlast,
  output logic [mpls_ingress_pkg::PORT_IDX_WIDTH-1:0]  out_tuser,
  input  logic                                         out_tready,

  output logic [mpls_ingress_pkg::NUM_ING_PORTS-1:0]   buf_overflow
);
  import mpls_ingress_pkg::*;

  // Upsizer to buffer
  logic [NUM_ING_PORTS-1:0] wide_valid;
  logic [CONV_WIDTH-1:0]    wide_data [NUM_ING_PORTS];
  logic [CONV_BYTES-1:0]    wide_keep [NUM_ING_PORTS];
  logic [NUM_ING_PORTS-1:0] wide_last;

  // Buffer to scheduler
  logic [NUM_ING_PORTS-1:0] pkt_valid;
  logic [CONV_WIDTH-1:0]    pkt_data [NUM_ING_PORTS];
  logic [CONV_BYTES-1:0]    pkt_keep [NUM_ING_PORTS];
  logic [NUM_ING_PORTS-1:0] pkt_last;
  logic [NUM_ING_PORTS-1:0] pkt_avail;
  logic [NUM_ING_PORTS-1:0] pkt_ready;

  ////////////////////////////////////////////////////////////
  // Width conversion per physical port

  // Byte port has no keep, each beat is one full byte
  ing_width_upsizer #(.IN_BYTES(1)) upsizer_8b_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_tvalid  (port8b_tvalid),
    .in_tdata   (port8b_tdata),
    .in_tkeep   (1'b1),
    .in_tlast   (port8b_tlast),
    .wide_valid (wide_valid[ING_8B_PORT]),
    .wide_data  (wide_data[ING_8B_PORT]),
    .wide_keep  (wide_keep[ING_8B_PORT]),
    .wide_last  (wide_last[ING_8B_PORT])
  );

  ing_width_upsizer #(.IN_BYTES(2)) upsizer_16b_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_tvalid  (port16b_tvalid),
    .in_tdata   (port16b_tdata),
    .in_tkeep   (port16b_tkeep),
    .in_tlast   (port16b_tlast),
    .wide_valid (wide_valid[ING_16B_PORT]),
    .wide_data  (wide_data[ING_16B_PORT]),
    .wide_keep  (wide_keep[ING_16B_PORT]),
    .wide_last  (wide_last[ING_16B_PORT])
  );

  ing_width_upsizer #(.IN_BYTES(4)) upsizer_32b_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_tvalid  (port32b_tvalid),
    .in_tdata   (port32b_tdata),
    .in_tkeep   (port32b_tkeep),
    .in_tlast   (port32b_tlast),
    .wide_valid (wide_valid[ING_32B_PORT]),
    .wide_data  (wide_data[ING_32B_PORT]),
    .wide_keep  (wide_keep[ING_32B_PORT]),
    .wide_last  (wide_last[ING_32B_PORT])
  );

  ing_width_upsizer #(.IN_BYTES(8)) upsizer_64b_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_tvalid  (port64b_tvalid),
    .in_tdata   (port64b_tdata),
    .in_tkeep   (port64b_tkeep),
    .in_tlast   (port64b_tlast),
    .wide_valid (wide_valid[ING_64B_PORT]),
    .wide_data  (wide_data[ING_64B_PORT]),
    .wide_keep  (wide_keep[ING_64B_PORT]),
    .wide_last  (wide_last[ING_64B_PORT])
  );

  ////////////////////////////////////////////////////////////
  // Packet buffers

  for (genvar p = 0; p < NUM_ING_PORTS; p++) begin : g_buf
    ing_pkt_buffer pkt_buffer_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .wide_valid (wide_valid[p]),
      .wide_data  (wide_data[p]),
      .wide_keep  (wide_keep[p]),
      .wide_last  (wide_last[p]),
      .pkt_ready  (pkt_ready[p]),
      .pkt_valid  (pkt_valid[p]),
      .pkt_data   (pkt_data[p]),
      .pkt_keep   (pkt_keep[p]),
      .pkt_last   (pkt_last[p]),
      .pkt_avail  (pkt_avail[p]),
      .overflow   (buf_overflow[p])
    );
  end

  ////////////////////////////////////////////////////////////
  // Merge onto the converged bus

  ing_rr_scheduler scheduler_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .pkt_avail  (pkt_avail),
    .pkt_valid  (pkt_valid),
    .pkt_data   (pkt_data),
    .pkt_keep   (pkt_keep),
    .pkt_last   (pkt_last),
    .out_tready (out_tready),
    .pkt_ready  (pkt_ready),
    .out_tvalid (out_tvalid),
    .out_tdata  (out_tdata),
    .out_tkeep  (out_tkeep),
    .out_tlast  (out_tlast),
    .out_tuser  (out_tuser)
  );

endmodule

// File: tb_clk_gen.sv
/* Free-running clock for the ingress testbench, 10 ns period by default. */
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter real PERIOD_NS = 10.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) clk = ~clk;
    end
  end

endmodule

// File: tb_mpls_ingress.sv
/* Testbench for the MPLS ingress stage. Drives the four physical ports, predicts
   the converged bus words per port and checks every transferred beat. */
`timescale 1ns/10ps

module tb_mpls_ingress;
  import mpls_ingress_pkg::*;

  localparam int BEAT_W = 1 + PORT_IDX_WIDTH + CONV_BYTES + CONV_WIDTH;

  logic clk;
  logic rst_n;
  logic port8b_tvalid, port8b_tlast;
  logic [7:0] port8b_tdata;
  logic port16b_tvalid, port16b_tlast;
  logic [15:0] port16b_tdata;
  logic [1:0] port16b_tkeep;
  logic port32b_tvalid, port32b_tlast;
  logic [31:0] port32b_tdata;
  logic [3:0] port32b_tkeep;
  logic port64b_tvalid, port64b_tlast;
  logic [63:0] port64b_tdata;
  logic [7:0] port64b_tkeep;
  logic out_tvalid, out_tlast, out_tready;
  logic [CONV_WIDTH-1:0] out_tdata;
  logic [CONV_BYTES-1:0] out_tkeep;
  logic [PORT_IDX_WIDTH-1:0] out_tuser;
  logic [NUM_ING_PORTS-1:0] buf_overflow;

  // Expected beats per port packed as {last, user, keep, data}
  logic [BEAT_W-1:0] exp_q [NUM_ING_PORTS][$];
  logic [PORT_IDX_WIDTH-1:0] order_q[$];
  integer seed;
  string test_name;
  int err_cnt, check_cnt, test_cnt, test_err_start, last_port, start_port;
  int ovf_cnt [NUM_ING_PORTS];
  // Port under test when only one port sends, otherwise -1
  int active_port;
  // Port of the packet in progress on the bus, -1 between packets
  int open_port;
  logic senders_busy;

  tb_clk_gen #(.PERIOD_NS(10.0)) clk_gen_i (.clk(clk));

  mpls_ingress mpls_ingress_i (.*);

  ////////////////////////////////////////////////////////////
  // Reference model and checking

  // Groups the bytes into 8-byte words and closes a word only at a beat boundary
  function automatic void pack_packet(input int width, input int port,
                                      input logic [7:0] bytes[$]);
    logic [CONV_WIDTH-1:0] acc;
    logic [CONV_BYTES-1:0] keep;
    int fill;
    logic last;
    acc = '0;
    keep = '0;
    fill = 0;
    for (int i = 0; i < bytes.size(); i++) begin
      acc[fill*8 +: 8] = bytes[i];
      keep[fill] = 1'b1;
      fill++;
      last = (i == bytes.size() - 1);
      if (((i + 1) % width == 0 || last) && (fill == CONV_BYTES || last)) begin
        exp_q[port].push_back({last, PORT_IDX_WIDTH'(port), keep, acc});
        acc = '0;
        keep = '0;
        fill = 0;
      end
    end
  endfunction

  task automatic check_value(input string what, input logic [CONV_WIDTH-1:0] expected,
                             input logic [CONV_WIDTH-1:0] actual);
    check_cnt++;
    if (expected !== actual) begin
      $display("ERROR %s %s: expected %h, actual %h", test_name, what, expected, actual);
      err_cnt++;
    end
  endtask

  function automatic bit queues_empty();
    bit empty;
    empty = 1'b1;
    for (int p = 0; p < NUM_ING_PORTS; p++) begin
      if (exp_q[p].size() != 0) begin
        empty = 1'b0;
      end
    end
    return empty;
  endfunction

  // Bus outputs are sampled at the rising edge where the beat transfers
  always @(posedge clk) begin
    int src;
    logic [BEAT_W-1:0] beat;
    if (rst_n) begin
      for (int p = 0; p < NUM_ING_PORTS; p++) begin
        if (buf_overflow[p]) ovf_cnt[p]++;
      end
      if (out_tvalid && out_tready) begin
        // With a single sender the source port is known from the stimulus
        src = (active_port >= 0) ? active_port : int'(out_tuser);
        if (open_port >= 0 && int'(out_tuser) != open_port) begin
          $display("Beat from port %0d interleaved into a packet from port %0d in test %s",
                   out_tuser, open_port, test_name);
          err_cnt++;
        end
        if (exp_q[src].size() == 0) begin
          $display("Unexpected beat from port %0d in test %s", src, test_name);
          err_cnt++;
        end else begin
          beat = exp_q[src].pop_front();
          check_value("tdata", beat[CONV_WIDTH-1:0], out_tdata);
          check_value("tkeep", beat[CONV_WIDTH +: CONV_BYTES], out_tkeep);
          if (active_port >= 0) begin
            check_value("tuser", beat[CONV_WIDTH+CONV_BYTES +: PORT_IDX_WIDTH], out_tuser);
          end
          check_value("tlast", beat[BEAT_W-1], out_tlast);
        end
        if (out_tlast) begin
          last_port = int'(out_tuser);
          order_q.push_back(out_tuser);
        end
        open_port = out_tlast ? -1 : int'(out_tuser);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus

  task automatic set_port(input int port, input logic v, input logic [63:0] d,
                          input logic [7:0] k, input logic l);
    case (port)
      0: begin
        port8b_tvalid = v;
        port8b_tdata = d[7:0];
        port8b_tlast = l;
      end
      1: begin
        port16b_tvalid = v;
        port16b_tdata = d[15:0];
        port16b_tkeep = k[1:0];
        port16b_tlast = l;
      end
      2: begin
        port32b_tvalid = v;
        port32b_tdata = d[31:0];
        port32b_tkeep = k[3:0];
        port32b_tlast = l;
      end
      default: begin
        port64b_tvalid = v;
        port64b_tdata = d;
        port64b_tkeep = k;
        port64b_tlast = l;
      end
    endcase
  endtask

  // Draws random bytes, predicts them when expected and sends one beat per falling edge
  task automatic send_packet(input int port, input int len, input bit expected);
    logic [7:0] bytes[$];
    logic [31:0] rnd;
    logic [63:0] data;
    logic [7:0] keep;
    int width, nbeats;
    width = 1 << port;
    nbeats = (len + width - 1) / width;
    for (int i = 0; i < len; i++) begin
      rnd = $random(seed);
      bytes.push_back(rnd[7:0]);
    end
    if (expected) pack_packet(width, port, bytes);
    for (int b = 0; b < nbeats; b++) begin
      data = '0;
      keep = '0;
      for (int i = 0; i < width; i++) begin
        if (b * width + i < len) begin
          data[i*8 +: 8] = bytes[b*width + i];
          keep[i] = 1'b1;
        end
      end
      @(negedge clk);
      set_port(port, 1'b1, data, keep, b == nbeats - 1);
    end
    @(negedge clk);
    set_port(port, 1'b0, '0, '0, 1'b0);
  endtask

  task automatic send_stream(input int port, input int count);
    logic [31:0] rnd;
    for (int n = 0; n < count; n++) begin
      rnd = $random(seed);
      send_packet(port, 1 + int'(rnd % 40), 1'b1);
      rnd = $random(seed);
      repeat (20 + int'(rnd % 20)) @(negedge clk);
    end
  endtask

  task automatic toggle_ready(input int limit);
    logic [31:0] rnd;
    int cycles;
    cycles = 0;
    while (senders_busy && cycles < limit) begin
      @(negedge clk);
      rnd = $random(seed);
      out_tready = rnd[0];
      cycles++;
    end
    if (senders_busy) begin
      $display("Timeout in test %s: port senders never finished", test_name);
      $display("Regression failed");
      $finish;
    end
  endtask

  task automatic wait_drain(input int limit);
    int cycles;
    cycles = 0;
    while (!queues_empty() && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!queues_empty()) begin
      $display("Timeout in test %s: expected packets never left the bus", test_name);
      $display("Regression failed");
      $finish;
    end
  endtask

  task automatic end_test();
    $display("Test %s finished with %0d errors", test_name, err_cnt - test_err_start);
    test_cnt++;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    seed = 32'hd20e;
    rst_n = 1'b0;
    out_tready = 1'b0;
    active_port = -1;
    open_port = -1;
    for (int p = 0; p < NUM_ING_PORTS; p++) begin
      set_port(p, 1'b0, '0, '0, 1'b0);
      ovf_cnt[p] = 0;
    end
    last_port = int'(ING_64B_PORT);
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    test_name = "reset_state";
    test_err_start = err_cnt;
    repeat (20) begin
      @(negedge clk);
      check_value("out_tvalid", 1'b0, out_tvalid);
      check_value("buf_overflow", '0, buf_overflow);
    end
    end_test();

    test_name = "single_port";
    test_err_start = err_cnt;
    out_tready = 1'b1;
    for (int p = 0; p < NUM_ING_PORTS; p++) begin
      active_port = p;
      repeat (6) send_packet(p, 1 + int'({$random(seed)} % 40), 1'b1);
      wait_drain(2000);
    end
    active_port = -1;
    end_test();

    test_name = "concurrent";
    test_err_start = err_cnt;
    senders_busy = 1'b1;
    fork
      begin
        fork
          send_stream(0, 8);
          send_stream(1, 8);
          send_stream(2, 8);
          send_stream(3, 8);
        join
        senders_busy = 1'b0;
      end
      toggle_ready(20000);
    join
    @(negedge clk);
    out_tready = 1'b1;
    wait_drain(5000);
    end_test();

    // All four packets are 8 beats long so they commit in the same cycle
    test_name = "round_robin";
    test_err_start = err_cnt;
    start_port = last_port;
    order_q.delete();
    @(negedge clk);
    out_tready = 1'b0;
    fork
      send_packet(0, 8, 1'b1);
      send_packet(1, 16, 1'b1);
      send_packet(2, 32, 1'b1);
      send_packet(3, 64, 1'b1);
    join
    repeat (3) @(negedge clk);
    out_tready = 1'b1;
    wait_drain(1000);
    check_value("packet count", NUM_ING_PORTS, order_q.size());
    for (int k = 0; k < NUM_ING_PORTS && k < order_q.size(); k++) begin
      check_value("port order", (start_port + 1 + k) % NUM_ING_PORTS, order_q[k]);
    end
    end_test();

    // 300 bytes is more than the 256-byte buffer, so that packet is dropped
    test_name = "overflow_drop";
    test_err_start = err_cnt;
    out_tready = 1'b0;
    send_packet(int'(ING_64B_PORT), 300, 1'b0);
    send_packet(int'(ING_64B_PORT), 20, 1'b1);
    repeat (3) @(negedge clk);
    out_tready = 1'b1;
    wait_drain(1000);
    repeat (5) @(negedge clk);
    for (int p = 0; p < NUM_ING_PORTS; p++) begin
      check_value("overflow pulses", (p == int'(ING_64B_PORT)) ? 1 : 0, ovf_cnt[p]);
    end
    end_test();

    $display("Tests run %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: project.f
mpls_ingress_pkg.sv
ing_width_upsizer.sv
ing_pkt_buffer.sv
ing_rr_scheduler.sv
mpls_ingress.sv
tb_clk_gen.sv
tb_mpls_ingress.sv
